// File: common/tlp_pkg.sv
// Shared TLP constants, type codes and the completion header builder
// All RTL blocks refer to these by tlp_pkg:: scoped names
package tlp_pkg;

  localparam int DATA_W       = 256;  // Stream beat width
  localparam int EMPTY_W      = 5;    // Empty byte count
  localparam int DW_W         = 32;
  localparam int DW_PER_BEAT  = DATA_W / DW_W;
  localparam int BAR_ADDR_W   = 16;   // 64 KiB region
  localparam int ID_W         = 16;
  localparam int TAG_W        = 8;
  localparam int LEN_W        = 10;
  localparam int BYTE_CNT_W   = 12;
  localparam int LOWER_ADDR_W = 7;

  // Dword positions within a beat, dword 0 sits in the top bits
  localparam int HDR_DW_ADDR  = 2;
  localparam int DATA_DW_AT3  = 3;    // Address bit 2 set
  localparam int DATA_DW_AT4  = 4;    // Qword aligned payload
  localparam int FMT_4DW_BIT  = 0;
  localparam int FMT_DATA_BIT = 1;

  typedef enum logic [2:0] {
    KIND_UNKNOWN,
    KIND_MRD,
    KIND_MRDLK,
    KIND_MWR,
    KIND_CPL,
    KIND_CPLD
  } tlp_kind_t;

  localparam logic [2:0] FMT_3DW_NODATA = 3'b000;
  localparam logic [2:0] FMT_3DW_DATA   = 3'b010;
  localparam logic [4:0] TYPE_MEM       = 5'b00000;
  localparam logic [4:0] TYPE_MEM_LK    = 5'b00001;
  localparam logic [4:0] TYPE_CPL       = 5'b01010;

  localparam logic [2:0] CPL_STATUS_SC = 3'b000;
  localparam logic [2:0] CPL_STATUS_UR = 3'b001;

  // Unused bytes at the end of a single beat completion
  localparam logic [EMPTY_W-1:0] EMPTY_HDR3     = 5'd20;
  localparam logic [EMPTY_W-1:0] EMPTY_DATA_AT3 = 5'd16;
  localparam logic [EMPTY_W-1:0] EMPTY_DATA_AT4 = 5'd12;

  // Three completion header dwords, dword 0 first
  function automatic logic [3*DW_W-1:0] cpl_header(
    input logic [2:0]              fmt,
    input logic [LEN_W-1:0]        len,
    input logic [ID_W-1:0]         completer_id,
    input logic [2:0]              status,
    input logic [BYTE_CNT_W-1:0]   byte_count,
    input logic [ID_W-1:0]         requester_id,
    input logic [TAG_W-1:0]        tag,
    input logic [LOWER_ADDR_W-1:0] lower_addr
  );
    return {fmt, TYPE_CPL, 14'b0, len,               // TC, TD, EP, attr all zero
            completer_id, status, 1'b0, byte_count,  // BCM clear
            requester_id, tag, 1'b0, lower_addr};
  endfunction

endpackage

// File: hdl/pcie_bar_target.sv
// PCIe BAR target endpoint top level
// Decodes receive TLPs into memory requests and sends the matching completions
`timescale 1ns/1ps
module pcie_bar_target (
  input  logic                               clk,
  input  logic                               reset,
  input  logic [tlp_pkg::DATA_W-1:0]         tlp_rx_data,
  input  logic                               tlp_rx_sop,
  input  logic                               tlp_rx_eop,
  input  logic                               tlp_rx_valid,
  output logic                               tlp_rx_ready,
  output logic [tlp_pkg::DATA_W-1:0]         tlp_tx_instant_data,
  output logic                               tlp_tx_instant_sop,
  output logic                               tlp_tx_instant_eop,
  output logic [tlp_pkg::EMPTY_W-1:0]        tlp_tx_instant_empty,
  output logic                               tlp_tx_instant_valid,
  input  logic                               tlp_tx_instant_ready,
  output logic [tlp_pkg::DATA_W-1:0]         tlp_tx_response_data,
  output logic                               tlp_tx_response_sop,
  output logic                               tlp_tx_response_eop,
  output logic [tlp_pkg::EMPTY_W-1:0]        tlp_tx_response_empty,
  output logic                               tlp_tx_response_valid,
  input  logic                               tlp_tx_response_ready,
  output logic                               mem_req_valid,
  input  logic                               mem_req_ready,
  output logic                               mem_req_write,
  output logic [tlp_pkg::BAR_ADDR_W-3:0]     mem_req_addr,
  output logic [tlp_pkg::ID_W-1:0]           mem_req_requester_id,
  output logic [tlp_pkg::TAG_W-1:0]          mem_req_tag,
  output logic [tlp_pkg::DW_W-1:0]           mem_req_wdata,
  input  logic                               mem_resp_valid,
  output logic                               mem_resp_ready,
  input  logic [tlp_pkg::ID_W-1:0]           mem_resp_requester_id,
  input  logic [tlp_pkg::TAG_W-1:0]          mem_resp_tag,
  input  logic [tlp_pkg::LOWER_ADDR_W-1:0]   mem_resp_lower_addr,
  input  logic [tlp_pkg::DW_W-1:0]           mem_resp_rdata,
  input  logic [tlp_pkg::ID_W-1:0]           completer_id,
  input  logic                               completer_id_valid,
  output logic                               ur_posted_err,
  output logic                               ur_nonposted_err
);

  logic                              rx_fire;
  logic                              frame_valid;
  tlp_pkg::tlp_kind_t                frame_kind;
  logic                              frame_npr;
  logic                              frame_unsupported;
  logic                              frame_zero_len;
  logic [tlp_pkg::ID_W-1:0]          frame_requester_id;
  logic [tlp_pkg::TAG_W-1:0]         frame_tag;
  logic [tlp_pkg::LOWER_ADDR_W-1:0]  frame_lower_addr;
  logic [tlp_pkg::BAR_ADDR_W-1:0]    frame_bar_addr;
  logic [tlp_pkg::DW_W-1:0]          frame_data;
  logic                              issue_busy;
  logic                              instant_busy;

  // No ID yet means completions could not be formed
  assign tlp_rx_ready = completer_id_valid && !issue_busy && !instant_busy;
  assign rx_fire      = tlp_rx_valid && tlp_rx_ready;

  tlp_rx_decode tlp_rx_decode_i (
    .clk, .reset, .rx_data(tlp_rx_data), .rx_fire,
    .frame_valid, .frame_kind, .frame_npr, .frame_unsupported, .frame_zero_len,
    .frame_requester_id, .frame_tag, .frame_lower_addr, .frame_bar_addr, .frame_data,
    .ur_posted_err, .ur_nonposted_err
  );

  mem_req_issue mem_req_issue_i (
    .clk, .reset, .frame_valid, .frame_kind, .frame_unsupported, .frame_zero_len,
    .frame_requester_id, .frame_tag, .frame_bar_addr, .frame_data, .mem_req_ready,
    .mem_req_valid, .mem_req_write, .mem_req_addr, .mem_req_requester_id, .mem_req_tag,
    .mem_req_wdata, .busy(issue_busy)
  );

  cpl_instant_sender cpl_instant_sender_i (
    .clk, .reset, .frame_valid, .frame_npr, .frame_unsupported, .frame_zero_len,
    .frame_requester_id, .frame_tag, .frame_lower_addr, .completer_id,
    .tx_ready(tlp_tx_instant_ready),
    .tx_data(tlp_tx_instant_data), .tx_sop(tlp_tx_instant_sop), .tx_eop(tlp_tx_instant_eop),
    .tx_empty(tlp_tx_instant_empty), .tx_valid(tlp_tx_instant_valid), .busy(instant_busy)
  );

  cpl_response_sender cpl_response_sender_i (
    .clk, .reset, .mem_resp_valid, .mem_resp_requester_id, .mem_resp_tag,
    .mem_resp_lower_addr, .mem_resp_rdata, .completer_id,
    .tx_ready(tlp_tx_response_ready), .mem_resp_ready,
    .tx_data(tlp_tx_response_data), .tx_sop(tlp_tx_response_sop),
    .tx_eop(tlp_tx_response_eop), .tx_empty(tlp_tx_response_empty),
    .tx_valid(tlp_tx_response_valid)
  );

  // Only single beat TLPs are handled
  rx_single_beat: assert property (@(posedge clk) disable iff (reset)
    rx_fire |-> tlp_rx_sop && tlp_rx_eop);

endmodule

// File: pcie_bar_target.f
+incdir+tests
common/tlp_pkg.sv
rx/tlp_rx_decode.sv
rx/mem_req_issue.sv
tx/cpl_instant_sender.sv
tx/cpl_response_sender.sv
hdl/pcie_bar_target.sv
tests/pcie_bar_target_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile the testbench with Verilator, run it and scan the log for failure
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f pcie_bar_target.f --top-module pcie_bar_target_tb -Mdir obj_dir

./obj_dir/Vpcie_bar_target_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "TEST RESULT: FAIL" sim.log; then
  exit 1
fi

// File: rx/mem_req_issue.sv
// Memory access request register for supported BAR reads and writes
// Holds one request until the memory side takes it
`timescale 1ns/1ps
module mem_req_issue (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              frame_valid,
  input  tlp_pkg::tlp_kind_t                frame_kind,
  input  logic                              frame_unsupported,
  input  logic                              frame_zero_len,
  input  logic [tlp_pkg::ID_W-1:0]          frame_requester_id,
  input  logic [tlp_pkg::TAG_W-1:0]         frame_tag,
  input  logic [tlp_pkg::BAR_ADDR_W-1:0]    frame_bar_addr,
  input  logic [tlp_pkg::DW_W-1:0]          frame_data,
  input  logic                              mem_req_ready,
  output logic                              mem_req_valid,
  output logic                              mem_req_write,
  output logic [tlp_pkg::BAR_ADDR_W-3:0]    mem_req_addr,      // Dword address
  output logic [tlp_pkg::ID_W-1:0]          mem_req_requester_id,
  output logic [tlp_pkg::TAG_W-1:0]         mem_req_tag,
  output logic [tlp_pkg::DW_W-1:0]          mem_req_wdata,
  output logic                              busy
);

  logic load;

  // Zero-length accesses never touch memory
  assign load = frame_valid && !frame_unsupported && !frame_zero_len &&
                (frame_kind inside {tlp_pkg::KIND_MRD, tlp_pkg::KIND_MWR});

  // Incoming frame or a request still waiting keeps receive stalled
  assign busy = frame_valid || (mem_req_valid && !mem_req_ready);

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_req_valid <= 1'b0;
    end else if (load) begin
      mem_req_valid <= 1'b1;
    end else if (mem_req_ready) begin
      mem_req_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      mem_req_write        <= (frame_kind == tlp_pkg::KIND_MWR);
      mem_req_addr         <= frame_bar_addr[tlp_pkg::BAR_ADDR_W-1:2];
      mem_req_requester_id <= frame_requester_id;
      mem_req_tag          <= frame_tag;
      mem_req_wdata        <= frame_data;  // Don't care on reads
    end
  end

  req_held_stable: assert property (@(posedge clk) disable iff (reset)
    mem_req_valid && !mem_req_ready |=> mem_req_valid &&
      $stable({mem_req_write, mem_req_addr, mem_req_requester_id, mem_req_tag, mem_req_wdata}));

endmodule

// File: rx/tlp_rx_decode.sv
// Receive TLP header decode for single beat requests
// Registers the frame fields on an accepted beat and flags unsupported requests
`timescale 1ns/1ps
module tlp_rx_decode (
  input  logic                                clk,
  input  logic                                reset,
  input  logic [tlp_pkg::DATA_W-1:0]          rx_data,
  input  logic                                rx_fire,       // Beat accepted
  output logic                                frame_valid,
  output tlp_pkg::tlp_kind_t                  frame_kind,
  output logic                                frame_npr,
  output logic                                frame_unsupported,
  output logic                                frame_zero_len,
  output logic [tlp_pkg::ID_W-1:0]            frame_requester_id,
  output logic [tlp_pkg::TAG_W-1:0]           frame_tag,
  output logic [tlp_pkg::LOWER_ADDR_W-1:0]    frame_lower_addr,
  output logic [tlp_pkg::BAR_ADDR_W-1:0]      frame_bar_addr,
  output logic [tlp_pkg::DW_W-1:0]            frame_data,
  output logic                                ur_posted_err,
  output logic                                ur_nonposted_err
);

  logic [tlp_pkg::DW_W-1:0]  dw [tlp_pkg::DW_PER_BEAT];
  logic [2:0]                fmt;
  logic [4:0]                raw_type;
  logic [tlp_pkg::LEN_W-1:0] len;
  logic [3:0]                first_be;
  logic [tlp_pkg::DW_W-1:0]  addr_dw;
  tlp_pkg::tlp_kind_t        kind;
  logic                      npr;
  logic                      posted;
  logic                      unsupported;
  logic                      frame_posted;

  // Dword 0 is the most significant one
  always_comb begin
    for (int i = 0; i < tlp_pkg::DW_PER_BEAT; i++) begin
      dw[i] = rx_data[tlp_pkg::DATA_W-1-i*tlp_pkg::DW_W -: tlp_pkg::DW_W];
    end
  end

  assign fmt      = dw[0][31:29];
  assign raw_type = dw[0][28:24];
  assign len      = dw[0][tlp_pkg::LEN_W-1:0];
  assign first_be = dw[1][3:0];
  assign addr_dw  = dw[tlp_pkg::HDR_DW_ADDR];

  always_comb begin
    case ({fmt[tlp_pkg::FMT_DATA_BIT], raw_type})
      {1'b0, tlp_pkg::TYPE_MEM}:    kind = tlp_pkg::KIND_MRD;
      {1'b0, tlp_pkg::TYPE_MEM_LK}: kind = tlp_pkg::KIND_MRDLK;
      {1'b1, tlp_pkg::TYPE_MEM}:    kind = tlp_pkg::KIND_MWR;
      {1'b0, tlp_pkg::TYPE_CPL}:    kind = tlp_pkg::KIND_CPL;
      {1'b1, tlp_pkg::TYPE_CPL}:    kind = tlp_pkg::KIND_CPLD;
      default:                      kind = tlp_pkg::KIND_UNKNOWN;
    endcase
  end

  // Non-posted requests need a completion
  always_comb begin
    npr    = 1'b0;
    posted = 1'b0;
    casez ({fmt[tlp_pkg::FMT_DATA_BIT], raw_type})
      6'b00000?: npr = 1'b1;     // MRd, MRdLk
      6'b?00010: npr = 1'b1;     // IO read or write
      6'b1011??: npr = 1'b1;     // Atomics
      6'b100000: posted = 1'b1;  // MWr
      6'b?10???: posted = 1'b1;  // Msg, MsgD
      default: ;
    endcase
  end

  always_comb begin
    unsupported = 1'b0;
    if (kind inside {tlp_pkg::KIND_UNKNOWN, tlp_pkg::KIND_CPL, tlp_pkg::KIND_MRDLK})
      unsupported = 1'b1;
    else if (fmt[tlp_pkg::FMT_4DW_BIT])
      unsupported = 1'b1;  // No 64-bit addressing
    else if (kind inside {tlp_pkg::KIND_MRD, tlp_pkg::KIND_MWR})
      unsupported = (len != 10'd1) || (first_be != 4'hf && first_be != 4'h0);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      frame_valid <= 1'b0;
    end else begin
      frame_valid <= rx_fire;  // One cycle per accepted beat
    end
  end

  always_ff @(posedge clk) begin
    if (rx_fire) begin
      frame_kind         <= kind;
      frame_npr          <= npr;
      frame_posted       <= posted;
      frame_unsupported  <= unsupported;
      frame_zero_len     <= (first_be == 4'h0);
      frame_requester_id <= dw[1][31:16];
      frame_tag          <= dw[1][15:8];
      frame_lower_addr   <= {addr_dw[tlp_pkg::LOWER_ADDR_W-1:2], 2'b00};
      frame_bar_addr     <= {addr_dw[tlp_pkg::BAR_ADDR_W-1:2], 2'b00};  // Offset in region
      // Payload starts qword aligned unless address bit 2 is set
      frame_data         <= addr_dw[2] ? dw[tlp_pkg::DATA_DW_AT3] : dw[tlp_pkg::DATA_DW_AT4];
    end
  end

  assign ur_posted_err    = frame_valid && frame_unsupported && frame_posted;
  assign ur_nonposted_err = frame_valid && frame_unsupported && frame_npr;

  // Receive ready must drop while a frame is on its way to the output registers
  frame_single_cycle: assert property (@(posedge clk) disable iff (reset)
    frame_valid |=> !frame_valid);

endmodule

// File: tests/tb_vectors.svh
// Receive TLP table for the BAR target testbench, included inside the testbench module
// Each row is one single beat request; the outcome column names the output it must produce
typedef enum logic [2:0] {
  OUT_WR,    // Memory write request
  OUT_RD,    // Memory read request, then CplD from the response
  OUT_ZLR,   // Instant CplD for a zero-length read
  OUT_UR,    // Instant UR completion plus non-posted error pulse
  OUT_PERR   // Posted error pulse only
} outcome_t;

typedef struct packed {
  outcome_t                 outcome;
  logic [tlp_pkg::DW_W-1:0] dw0;    // Fmt, type, length
  logic [tlp_pkg::DW_W-1:0] dw1;    // Requester ID, tag, byte enables
  logic [tlp_pkg::DW_W-1:0] addr;   // Header dword 2
  logic [tlp_pkg::DW_W-1:0] dw3;
  logic [tlp_pkg::DW_W-1:0] dw4;
  logic [tlp_pkg::DW_W-1:0] rdata;  // Returned by the memory model on reads
} vector_t;

localparam int NUM_VECTORS = 12;

vector_t vec [NUM_VECTORS];

// Columns: outcome, dword 0, dword 1, dword 2, dword 3, dword 4, read data
task automatic load_vectors();
  vec[0]  = '{OUT_WR,   'h40000001, 'h0100110f, 'hf0001230, 'hdead0003, 'h11112222, 'h0};
  vec[1]  = '{OUT_WR,   'h40000001, 'h1a2b120f, 'h0000abc4, 'h33334444, 'hbad00004, 'h0};
  vec[2]  = '{OUT_RD,   'h00000001, 'h0100210f, 'h12345678, 'h0, 'h0, 'hcafe0001};
  vec[3]  = '{OUT_RD,   'h00000001, 'h1a2b220f, 'h00000ff4, 'h0, 'h0, 'hcafe0002};
  vec[4]  = '{OUT_ZLR,  'h00000001, 'h01002300, 'h00000040, 'h0, 'h0, 'h0};
  vec[5]  = '{OUT_UR,   'h01000001, 'h0100240f, 'h00000010, 'h0, 'h0, 'h0};  // MRdLk
  vec[6]  = '{OUT_UR,   'h20000001, 'h0100250f, 'h00000000, 'h00000080, 'h0, 'h0};  // 4DW
  vec[7]  = '{OUT_UR,   'h00000002, 'h010026ff, 'h00000100, 'h0, 'h0, 'h0};  // Length 2
  vec[8]  = '{OUT_PERR, 'h40000002, 'h010027ff, 'h00000200, 'h55556666, 'h77778888, 'h0};
  vec[9]  = '{OUT_WR,   'h40000001, 'h7f01280f, 'hfffffffc, 'h9abcdef0, 'hbad00009, 'h0};
  vec[10] = '{OUT_RD,   'h00000001, 'h7f01290f, 'h00010008, 'h0, 'h0, 'h12345678};
  vec[11] = '{OUT_RD,   'h00000001, 'h0a0b2a0f, 'ha5a55a5c, 'h0, 'h0, 'h87654321};
endtask

// File: tests/pcie_bar_target_tb.sv
// Testbench for the PCIe BAR target, drives the receive TLP table under random back-pressure
// Checks every memory request, completion and error pulse in order against expected values
`timescale 1ns/1ps
module pcie_bar_target_tb;

  `include "tb_vectors.svh"

  localparam int CYCLE_LIMIT = 64 * NUM_VECTORS;  // Whole run, reset included
  localparam logic [tlp_pkg::ID_W-1:0] COMPLETER = 16'hbeef;

  typedef struct packed {
    logic                           write;
    logic [tlp_pkg::BAR_ADDR_W-3:0] addr;  // Dword address
    logic [tlp_pkg::ID_W-1:0]       rid;
    logic [tlp_pkg::TAG_W-1:0]      tag;
    logic [tlp_pkg::DW_W-1:0]       wdata;
  } mem_req_t;

  typedef struct packed {
    logic [tlp_pkg::ID_W-1:0]         rid;
    logic [tlp_pkg::TAG_W-1:0]        tag;
    logic [tlp_pkg::LOWER_ADDR_W-1:0] laddr;
    logic [tlp_pkg::DW_W-1:0]         rdata;
  } mem_resp_t;

  typedef struct packed {
    logic [tlp_pkg::DATA_W-1:0]  data;
    logic                        sop;
    logic                        eop;
    logic [tlp_pkg::EMPTY_W-1:0] empty;
  } cpl_t;

  logic clk = 1'b0;
  logic reset;
  logic [tlp_pkg::DATA_W-1:0] tlp_rx_data;
  logic tlp_rx_sop, tlp_rx_eop, tlp_rx_valid, tlp_rx_ready;
  logic [tlp_pkg::DATA_W-1:0] tlp_tx_instant_data, tlp_tx_response_data;
  logic tlp_tx_instant_sop, tlp_tx_instant_eop, tlp_tx_instant_valid;
  logic tlp_tx_response_sop, tlp_tx_response_eop, tlp_tx_response_valid;
  logic [tlp_pkg::EMPTY_W-1:0] tlp_tx_instant_empty, tlp_tx_response_empty;
  logic tlp_tx_instant_ready = 1'b0;
  logic tlp_tx_response_ready = 1'b0;
  logic mem_req_ready = 1'b0;
  logic mem_req_valid, mem_req_write;
  logic [tlp_pkg::BAR_ADDR_W-3:0] mem_req_addr;
  logic [tlp_pkg::ID_W-1:0] mem_req_requester_id;
  logic [tlp_pkg::TAG_W-1:0] mem_req_tag;
  logic [tlp_pkg::DW_W-1:0] mem_req_wdata;
  logic mem_resp_valid = 1'b0;
  logic mem_resp_ready;
  logic [tlp_pkg::ID_W-1:0] mem_resp_requester_id = '0;
  logic [tlp_pkg::TAG_W-1:0] mem_resp_tag = '0;
  logic [tlp_pkg::LOWER_ADDR_W-1:0] mem_resp_lower_addr = '0;
  logic [tlp_pkg::DW_W-1:0] mem_resp_rdata = '0;
  logic [tlp_pkg::ID_W-1:0] completer_id;
  logic completer_id_valid;
  logic ur_posted_err, ur_nonposted_err;

  logic [31:0] lfsr_state = 32'hc3bff751;
  int          cycle_count = 0;
  mem_resp_t   resp_item;

  mem_req_t    exp_mem_q [$];
  mem_resp_t   read_q [$];          // Response data for reads not yet issued
  mem_resp_t   pending_resp_q [$];  // Issued reads awaiting the memory model
  cpl_t        exp_inst_q [$];
  cpl_t        exp_resp_q [$];
  logic [1:0]  exp_err_q [$];       // {posted, non-posted}

  pcie_bar_target pcie_bar_target_i (.*);

  always #4 clk = ~clk;

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) return (state >> 1) ^ 32'h8020_0003;  // Taps 32, 22, 2, 1
    return state >> 1;
  endfunction

  // Three dword completion header per the PCIe layout, rest of the beat zero
  function automatic logic [tlp_pkg::DATA_W-1:0] completion_beat(
    input logic [2:0] fmt, input logic [9:0] len, input logic [2:0] status,
    input logic [11:0] bcnt, input logic [15:0] rid, input logic [7:0] tag,
    input logic [6:0] laddr);
    logic [tlp_pkg::DATA_W-1:0] beat;
    beat            = '0;
    beat[255:253]   = fmt;
    beat[252:248]   = 5'b01010;  // Cpl type
    beat[233:224]   = len;
    beat[223:208]   = COMPLETER;
    beat[207:205]   = status;
    beat[203:192]   = bcnt;
    beat[191:176]   = rid;
    beat[175:168]   = tag;
    beat[166:160]   = laddr;
    return beat;
  endfunction

  function automatic cpl_t read_cpl(input mem_resp_t r);
    logic [tlp_pkg::DATA_W-1:0] beat;
    beat = completion_beat(3'b010, 10'd1, 3'b000, 12'd4, r.rid, r.tag, r.laddr);
    if (r.laddr[2]) beat[159:128] = r.rdata;  // Dword 3, no pad
    else beat[127:96] = r.rdata;              // Dword 4 after pad
    return {beat, 1'b1, 1'b1, (r.laddr[2] ? 5'd16 : 5'd12)};
  endfunction

  task automatic compare_mem_req(input mem_req_t got, input mem_req_t exp);
    if (got.write !== exp.write || got.addr !== exp.addr || got.rid !== exp.rid ||
        got.tag !== exp.tag || (exp.write && got.wdata !== exp.wdata))
      report_error($sformatf("MISMATCH at %0t: memory request %h, expected %h",
                             $time, got, exp));
  endtask

  task automatic compare_instant(input cpl_t got, input cpl_t exp);
    if (got !== exp)
      report_error($sformatf("MISMATCH at %0t: instant completion %h, expected %h",
                             $time, got, exp));
  endtask

  task automatic compare_response(input cpl_t got, input cpl_t exp);
    if (got !== exp)
      report_error($sformatf("MISMATCH at %0t: response completion %h, expected %h",
                             $time, got, exp));
  endtask

  task automatic compare_err(input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp)
      report_error($sformatf("MISMATCH at %0t: UR pulses posted/non-posted %b, expected %b",
                             $time, got, exp));
  endtask

  // Beat offered on the receive stream and its expected results queued
  task automatic present_row(input int idx);
    vector_t                          v;
    logic [tlp_pkg::ID_W-1:0]         rid;
    logic [tlp_pkg::TAG_W-1:0]        tag;
    logic [tlp_pkg::LOWER_ADDR_W-1:0] laddr;
    logic [tlp_pkg::DW_W-1:0]         wdata;
    v     = vec[idx];
    rid   = v.dw1[31:16];
    tag   = v.dw1[15:8];
    laddr = {v.addr[6:2], 2'b00};
    wdata = v.addr[2] ? v.dw3 : v.dw4;  // Payload qword aligned
    tlp_rx_data  <= {v.dw0, v.dw1, v.addr, v.dw3, v.dw4, 96'h0};
    tlp_rx_sop   <= 1'b1;
    tlp_rx_eop   <= 1'b1;
    tlp_rx_valid <= 1'b1;
    case (v.outcome)
      OUT_WR: exp_mem_q.push_back({1'b1, v.addr[15:2], rid, tag, wdata});
      OUT_RD: begin
        exp_mem_q.push_back({1'b0, v.addr[15:2], rid, tag, 32'h0});
        read_q.push_back({rid, tag, laddr, v.rdata});
        exp_resp_q.push_back(read_cpl({rid, tag, laddr, v.rdata}));
      end
      OUT_ZLR: exp_inst_q.push_back({completion_beat(3'b010, 10'd0, 3'b000, 12'd0,
                                                      rid, tag, laddr), 1'b1, 1'b1, 5'd20});
      OUT_UR: begin
        exp_inst_q.push_back({completion_beat(3'b000, 10'd0, 3'b001, 12'd4,
                                              rid, tag, laddr), 1'b1, 1'b1, 5'd20});
        exp_err_q.push_back(2'b01);
      end
      OUT_PERR: exp_err_q.push_back(2'b10);
      default: ;
    endcase
  endtask

  task automatic take_mem_req();
    mem_req_t exp;
    if (exp_mem_q.size() == 0) begin
      report_error("memory request issued with none expected");
    end else begin
      exp = exp_mem_q.pop_front();
      if (!exp.write && read_q.size() != 0) pending_resp_q.push_back(read_q.pop_front());
      compare_mem_req({mem_req_write, mem_req_addr, mem_req_requester_id, mem_req_tag,
                       mem_req_wdata}, exp);
    end
  endtask

  task automatic take_instant();
    if (exp_inst_q.size() == 0)
      report_error("instant completion sent with none expected");
    else
      compare_instant({tlp_tx_instant_data, tlp_tx_instant_sop, tlp_tx_instant_eop,
                       tlp_tx_instant_empty}, exp_inst_q.pop_front());
  endtask

  task automatic take_response();
    if (exp_resp_q.size() == 0)
      report_error("response completion sent with none expected");
    else
      compare_response({tlp_tx_response_data, tlp_tx_response_sop, tlp_tx_response_eop,
                        tlp_tx_response_empty}, exp_resp_q.pop_front());
  endtask

  task automatic take_err();
    if (exp_err_q.size() == 0)
      report_error("UR error pulse with none expected");
    else
      compare_err({ur_posted_err, ur_nonposted_err}, exp_err_q.pop_front());
  endtask

  function automatic int outstanding();
    return exp_mem_q.size() + read_q.size() + pending_resp_q.size() +
           exp_inst_q.size() + exp_resp_q.size() + exp_err_q.size();
  endfunction

  // Random ready on every output, one LFSR step per bit
  always @(posedge clk) begin
    lfsr_state = lfsr_next(lfsr_state);
    mem_req_ready <= lfsr_state[0];
    lfsr_state = lfsr_next(lfsr_state);
    tlp_tx_instant_ready <= lfsr_state[0];
    lfsr_state = lfsr_next(lfsr_state);
    tlp_tx_response_ready <= lfsr_state[0];
  end

  // Memory model answers each issued read in order
  always begin : memory_model
    @(posedge clk);
    if (pending_resp_q.size() != 0) begin
      resp_item = pending_resp_q.pop_front();
      mem_resp_valid        <= 1'b1;
      mem_resp_requester_id <= resp_item.rid;
      mem_resp_tag          <= resp_item.tag;
      mem_resp_lower_addr   <= resp_item.laddr;
      mem_resp_rdata        <= resp_item.rdata;
      do @(negedge clk); while (!mem_resp_ready);  // Transfer on the next rising edge
      @(posedge clk);
      mem_resp_valid <= 1'b0;
    end
  end

  // Handshakes sampled mid-cycle, transfer happens on the following edge
  always @(negedge clk) begin
    if (!reset) begin
      if (mem_req_valid && mem_req_ready) take_mem_req();
      if (tlp_tx_instant_valid && tlp_tx_instant_ready) take_instant();
      if (tlp_tx_response_valid && tlp_tx_response_ready) take_response();
      if (ur_posted_err || ur_nonposted_err) take_err();
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT)
      report_error($sformatf("Timeout after %0d cycles with %0d results outstanding",
                             cycle_count, outstanding()));
  end

  initial begin : stimulus
    reset              = 1'b1;
    tlp_rx_data        = '0;
    tlp_rx_sop         = 1'b0;
    tlp_rx_eop         = 1'b0;
    tlp_rx_valid       = 1'b0;
    completer_id       = COMPLETER;
    completer_id_valid = 1'b0;
    load_vectors();
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    present_row(0);  // Offered before the completer ID is known
    repeat (10) begin
      @(negedge clk);
      if (tlp_rx_ready)
        report_error("Receive ready went high while the completer ID was not valid");
      if (mem_req_valid || tlp_tx_instant_valid || tlp_tx_response_valid ||
          ur_posted_err || ur_nonposted_err)
        report_error("Output activity while the completer ID was not valid");
    end
    @(posedge clk);
    completer_id_valid <= 1'b1;
    for (int i = 0; i < NUM_VECTORS; i++) begin
      if (i > 0) present_row(i);
      do @(negedge clk); while (!tlp_rx_ready);
      @(posedge clk);  // Beat accepted here
    end
    tlp_rx_valid <= 1'b0;
    tlp_rx_sop   <= 1'b0;
    tlp_rx_eop   <= 1'b0;
    while (outstanding() != 0) @(negedge clk);
    repeat (16) @(negedge clk);  // Window for late duplicates
    if (outstanding() == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      report_error("Expected results still outstanding at the end of the run");
    end
  end

endmodule

// File: tx/cpl_instant_sender.sv
// Immediate completions that need no memory access
// UR for unsupported non-posted requests and empty CplD for zero-length reads
`timescale 1ns/1ps
module cpl_instant_sender (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               frame_valid,
  input  logic                               frame_npr,
  input  logic                               frame_unsupported,
  input  logic                               frame_zero_len,
  input  logic [tlp_pkg::ID_W-1:0]           frame_requester_id,
  input  logic [tlp_pkg::TAG_W-1:0]          frame_tag,
  input  logic [tlp_pkg::LOWER_ADDR_W-1:0]   frame_lower_addr,
  input  logic [tlp_pkg::ID_W-1:0]           completer_id,
  input  logic                               tx_ready,
  output logic [tlp_pkg::DATA_W-1:0]         tx_data,
  output logic                               tx_sop,
  output logic                               tx_eop,
  output logic [tlp_pkg::EMPTY_W-1:0]        tx_empty,
  output logic                               tx_valid,
  output logic                               busy
);

  localparam int PAD_W = tlp_pkg::DATA_W - 3 * tlp_pkg::DW_W;

  logic load_ur;
  logic load_zl;

  assign load_ur = frame_valid && frame_npr && frame_unsupported;
  assign load_zl = frame_valid && frame_npr && !frame_unsupported && frame_zero_len;
  assign busy    = frame_valid || (tx_valid && !tx_ready);

  always_ff @(posedge clk) begin
    if (reset) begin
      tx_valid <= 1'b0;
      tx_sop   <= 1'b0;
      tx_eop   <= 1'b0;
    end else if (load_ur || load_zl) begin
      tx_valid <= 1'b1;
      tx_sop   <= 1'b1;  // Single beat TLP
      tx_eop   <= 1'b1;
    end else if (tx_ready) begin
      tx_valid <= 1'b0;
      tx_sop   <= 1'b0;
      tx_eop   <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load_ur) begin
      // Cpl without data and with status UR
      tx_data <= {tlp_pkg::cpl_header(tlp_pkg::FMT_3DW_NODATA, 10'd0, completer_id,
                                      tlp_pkg::CPL_STATUS_UR, 12'd4, frame_requester_id,
                                      frame_tag, frame_lower_addr), {PAD_W{1'b0}}};
    end else if (load_zl) begin
      tx_data <= {tlp_pkg::cpl_header(tlp_pkg::FMT_3DW_DATA, 10'd0, completer_id,
                                      tlp_pkg::CPL_STATUS_SC, 12'd0, frame_requester_id,
                                      frame_tag, frame_lower_addr), {PAD_W{1'b0}}};
    end
  end

  assign tx_empty = tlp_pkg::EMPTY_HDR3;  // Header only in both cases

  // Completion stays unchanged under back-pressure
  held_until_ready: assert property (@(posedge clk) disable iff (reset)
    tx_valid && !tx_ready |=> tx_valid && $stable(tx_data));

endmodule

// File: tx/cpl_response_sender.sv
// CplD builder for memory read responses
// One response register, refilled in the same cycle it drains
`timescale 1ns/1ps
module cpl_response_sender (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               mem_resp_valid,
  input  logic [tlp_pkg::ID_W-1:0]           mem_resp_requester_id,
  input  logic [tlp_pkg::TAG_W-1:0]          mem_resp_tag,
  input  logic [tlp_pkg::LOWER_ADDR_W-1:0]   mem_resp_lower_addr,
  input  logic [tlp_pkg::DW_W-1:0]           mem_resp_rdata,
  input  logic [tlp_pkg::ID_W-1:0]           completer_id,
  input  logic                               tx_ready,
  output logic                               mem_resp_ready,
  output logic [tlp_pkg::DATA_W-1:0]         tx_data,
  output logic                               tx_sop,
  output logic                               tx_eop,
  output logic [tlp_pkg::EMPTY_W-1:0]        tx_empty,
  output logic                               tx_valid
);

  localparam int DATA_HI = tlp_pkg::DATA_W - 1;

  logic load;

  assign mem_resp_ready = !tx_valid || tx_ready;  // Empty or draining
  assign load           = mem_resp_valid && mem_resp_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      tx_valid <= 1'b0;
      tx_sop   <= 1'b0;
      tx_eop   <= 1'b0;
    end else if (load) begin
      tx_valid <= 1'b1;
      tx_sop   <= 1'b1;
      tx_eop   <= 1'b1;
    end else if (tx_ready) begin
      tx_valid <= 1'b0;
      tx_sop   <= 1'b0;
      tx_eop   <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      tx_data <= '0;
      tx_data[DATA_HI -: 3*tlp_pkg::DW_W] <=
        tlp_pkg::cpl_header(tlp_pkg::FMT_3DW_DATA, 10'd1, completer_id,
                            tlp_pkg::CPL_STATUS_SC, 12'd4, mem_resp_requester_id,
                            mem_resp_tag, mem_resp_lower_addr);
      // Qword aligned address pads the header with one dword
      if (!mem_resp_lower_addr[2]) begin
        tx_data[DATA_HI - tlp_pkg::DATA_DW_AT4*tlp_pkg::DW_W -: tlp_pkg::DW_W] <= mem_resp_rdata;
        tx_empty <= tlp_pkg::EMPTY_DATA_AT4;
      end else begin
        tx_data[DATA_HI - tlp_pkg::DATA_DW_AT3*tlp_pkg::DW_W -: tlp_pkg::DW_W] <= mem_resp_rdata;
        tx_empty <= tlp_pkg::EMPTY_DATA_AT3;
      end
    end
  end

endmodule
